// ==== build.f ====
verilog/csrPkg.sv
verilog/csrDecode.sv
verilog/csrExecute.sv
verilog/csrCounters.sv
verilog/csrUnit.sv
tb/csrChecker.sv
tb/csrUnit_asserts.sv
tb/csrUnit_tb.sv

// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - files:
      - verilog/csrPkg.sv
      - verilog/csrDecode.sv
      - verilog/csrExecute.sv
      - verilog/csrCounters.sv
      - verilog/csrUnit.sv
  - target: test
    files:
      - tb/csrChecker.sv
      - tb/csrUnit_asserts.sv
      - tb/csrUnit_tb.sv

// ==== tb/csrUnit_tb.sv ====
module csrUnit_tb import csrPkg::*; ();

    localparam int COMMIT_WIDTH = 4;
    localparam int CW           = $clog2(COMMIT_WIDTH + 1);
    localparam int N_RMW        = 40;
    localparam int N_TRAP       = 6;
    localparam int N_IRQ        = 16;
    localparam int N_COMMIT     = 20;
    localparam int TOTAL_REQS   = N_RMW + 10 + 8 * N_TRAP + 12 + 4 * N_IRQ;
    localparam int LIMIT        = TOTAL_REQS * 4 + 200;
    localparam tag_t NOWB       = 6'h20; // no write-back

    logic          clk = 1'b0;
    logic          rst;
    csrReq_t       req;
    trapInfo_t     trap;
    logic [CW-1:0] commitCount;
    logic          timerIrq;
    csrResult_t    res;
    trapCtrl_t     trapCtl;

    integer seed   = 32'h4b70;
    int     cycles = 0;

    // reference state
    logic [1:0]  mPriv    = 2'd3;
    logic        mMie     = 1'b0;
    logic        mMpie    = 1'b0;
    logic [1:0]  mMpp     = 2'd0;
    xlen_t       mTvec    = '0;
    xlen_t       mEpc     = '0;
    xlen_t       mCause   = '0;
    xlen_t       mTval    = '0;
    xlen_t       mScratch = '0;
    xlen_t       mIe      = '0;
    logic        mipMsi   = 1'b0;
    logic        mipMti   = 1'b0;
    logic [30:0] mRetvec  = '0;
    logic [2:0]  mInhibit = '0;
    counter_t    mCycle   = '0;
    counter_t    mInstret = '0;

    csrUnit #(.COMMIT_WIDTH(COMMIT_WIDTH)) dut0 (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .trap        (trap),
        .commitCount (commitCount),
        .timerIrq    (timerIrq),
        .res         (res),
        .trapCtl     (trapCtl)
    );

    csrChecker chk0 (
        .clk     (clk),
        .rst     (rst),
        .res     (res),
        .trapCtl (trapCtl)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic addrKnown(input csrAddr_t a);
        return a inside {ADDR_MSTATUS, ADDR_MISA, ADDR_MIE, ADDR_MTVEC, ADDR_MCOUNTINHIBIT,
                         ADDR_MSCRATCH, ADDR_MEPC, ADDR_MCAUSE, ADDR_MTVAL, ADDR_MIP,
                         ADDR_MCYCLE, ADDR_MINSTRET, ADDR_MCYCLEH, ADDR_MINSTRETH,
                         ADDR_MVENDORID, ADDR_MHARTID};
    endfunction

    function automatic xlen_t readModel(input csrAddr_t a);
        xlen_t v;
        v = '0;
        case (a)
            ADDR_MSTATUS: begin
                v[3]     = mMie;
                v[7]     = mMpie;
                v[12:11] = mMpp;
            end
            ADDR_MISA:          v = MISA_VALUE;
            ADDR_MIE:           v = mIe;
            ADDR_MTVEC:         v = mTvec;
            ADDR_MCOUNTINHIBIT: v = {29'b0, mInhibit};
            ADDR_MSCRATCH:      v = mScratch;
            ADDR_MEPC:          v = mEpc;
            ADDR_MCAUSE:        v = mCause;
            ADDR_MTVAL:         v = mTval;
            ADDR_MIP: begin
                v[IRQ_MSI] = mipMsi;
                v[IRQ_MTI] = mipMti;
            end
            ADDR_MCYCLE:        v = mCycle[31:0];
            ADDR_MCYCLEH:       v = mCycle[63:32];
            ADDR_MINSTRET:      v = mInstret[31:0];
            ADDR_MINSTRETH:     v = mInstret[63:32];
            default:            v = '0;
        endcase
        return v;
    endfunction

    function automatic void writeModel(input csrAddr_t a, input xlen_t v);
        case (a)
            ADDR_MSTATUS: begin
                mMie  = v[3];
                mMpie = v[7];
                mMpp  = (v[12:11] == 2'b11) ? 2'd3 : 2'd0;
            end
            ADDR_MIE:           mIe = v & 32'h88;
            ADDR_MTVEC:         mTvec = v & ~32'h3;
            ADDR_MEPC:          mEpc = v & ~32'h1;
            ADDR_MCAUSE:        mCause = v & 32'h8000_000F;
            ADDR_MTVAL:         mTval = v;
            ADDR_MSCRATCH:      mScratch = v;
            ADDR_MIP:           mipMsi = v[IRQ_MSI];
            ADDR_MCYCLE:        mCycle[31:0] = v;
            ADDR_MCYCLEH:       mCycle[63:32] = v;
            ADDR_MINSTRET:      mInstret[31:0] = v;
            ADDR_MINSTRETH:     mInstret[63:32] = v;
            ADDR_MCOUNTINHIBIT: mInhibit = {v[2], 1'b0, v[0]};
            default: ;
        endcase
    endfunction

    function automatic trapCtrl_t expectedCtrl();
        trapCtrl_t c;
        logic      en;
        en                 = mMie || (mPriv == 2'd0);
        c.priv             = privLevel_t'(mPriv);
        c.mtvecBase        = mTvec[31:2];
        c.retvec           = mRetvec;
        c.interruptPending = 1'b0;
        c.interruptCause   = '0;
        if (en && mipMti && mIe[IRQ_MTI]) begin
            c.interruptPending = 1'b1;
            c.interruptCause   = cause_t'(IRQ_MTI);
        end else if (en && mipMsi && mIe[IRQ_MSI]) begin
            c.interruptPending = 1'b1;
            c.interruptCause   = cause_t'(IRQ_MSI);
        end
        return c;
    endfunction

    function automatic tag_t nextTag();
        xlen_t r;
        r = $random(seed);
        return r[5:0];
    endfunction

    // read-backs need their data returned
    function automatic tag_t writebackTag();
        tag_t t;
        t    = nextTag();
        t[5] = 1'b0;
        return t;
    endfunction

    // model the access, queue its result, then drive it
    task automatic issue(input string name, input csrOp_t op, input csrAddr_t addr,
                         input xlen_t src, input tag_t tag);
        csrReq_t      r;
        xlen_t        old;
        xlen_t        opnd;
        xlen_t        wv;
        logic         wr;
        logic         bad;
        resultFlags_t fl;
        old  = readModel(addr);
        wr   = !(op inside {CSR_R, CSR_MRET});
        opnd = (op inside {CSR_RWI, CSR_RSI, CSR_RCI}) ? {27'b0, src[4:0]} : src;
        if (op == CSR_MRET) begin
            bad = (mPriv == 2'd0);
        end else begin
            bad = !addrKnown(addr) || (mPriv < addr[9:8])
                  || (wr && (addr[11:10] == 2'b11 || addr == ADDR_MISA));
        end
        if (bad) fl = FLAGS_ILLEGAL;
        else if (op == CSR_MRET) fl = FLAGS_XRET;
        else if (wr) fl = FLAGS_ORDERING;
        else fl = FLAGS_NONE;
        chk0.expectResult(name, tag, fl, (tag[5] || bad) ? '0 : old);
        if (!bad && op == CSR_MRET) begin
            mMie    = mMpie;
            mPriv   = mMpp;
            mMpp    = 2'd0;
            mRetvec = mEpc[31:1];
        end else if (!bad && wr) begin
            case (op)
                CSR_RS, CSR_RSI: wv = old | opnd;
                CSR_RC, CSR_RCI: wv = old & ~opnd;
                default:         wv = opnd;
            endcase
            writeModel(addr, wv);
        end
        r = '{valid: 1'b1, op: op, addr: addr, src: src, uimm: src[4:0], tag: tag};
        @(posedge clk);
        req <= r;
    endtask

    task automatic stopRequests();
        @(posedge clk);
        req.valid <= 1'b0;
    endtask

    task automatic drain();
        while (chk0.outstanding() != 0) @(negedge clk);
    endtask

    task automatic sendTrap();
        trapInfo_t t;
        xlen_t     rnd;
        rnd           = $random(seed);
        t.valid       = 1'b1;
        t.isInterrupt = rnd[31];
        t.cause       = rnd[3:0];
        t.pc          = $random(seed);
        t.tval        = $random(seed);
        @(posedge clk);
        trap <= t;
        @(posedge clk);
        trap.valid <= 1'b0;
        mEpc  = {t.pc[31:1], 1'b0};
        mCause = {t.isInterrupt, 27'b0, t.cause};
        mTval = t.tval;
        mMpie = mMie;
        mMie  = 1'b0;
        mMpp  = mPriv;
        mPriv = 2'd3;
    endtask

    task automatic ensureMachine();
        if (mPriv == 2'd0) sendTrap();
    endtask

    initial begin
        int       i;
        int       c;
        int       sum;
        xlen_t    r;
        csrOp_t   op;
        csrAddr_t addr;
        counter_t cntA;
        counter_t cntB;
        rst         = 1'b1;
        req         = '0;
        trap        = '0;
        commitCount = '0;
        timerIrq    = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        for (i = 0; i < N_RMW; i++) begin
            op = csrOp_t'($unsigned($random(seed)) % 7); // any op but mret
            case ($unsigned($random(seed)) % 3)
                0:       addr = ADDR_MSCRATCH;
                1:       addr = ADDR_MTVEC;
                default: addr = ADDR_MEPC;
            endcase
            issue("rmw", op, addr, $random(seed), nextTag());
        end
        stopRequests();
        drain();
        chk0.endTest("rmw");

        issue("illegal", CSR_R, 12'h7C0, '0, nextTag());
        issue("illegal", CSR_RW, 12'h123, $random(seed), nextTag());
        issue("illegal", CSR_RW, ADDR_MISA, $random(seed), nextTag());
        issue("illegal", CSR_R, ADDR_MISA, '0, writebackTag());
        issue("illegal", CSR_RS, ADDR_MHARTID, $random(seed), nextTag());
        issue("illegal", CSR_R, ADDR_MHARTID, '0, nextTag());
        issue("illegal", CSR_MRET, '0, '0, nextTag()); // MPP is user here
        issue("illegal", CSR_R, ADDR_MSCRATCH, '0, nextTag());
        issue("illegal", CSR_RW, ADDR_MEPC, $random(seed), nextTag());
        issue("illegal", CSR_MRET, '0, '0, nextTag());
        stopRequests();
        drain();
        chk0.checkCtrl("illegal", expectedCtrl());
        chk0.endTest("illegal");

        for (i = 0; i < N_TRAP; i++) begin
            sendTrap();
            chk0.checkCtrl("trap", expectedCtrl());
            issue("trap", CSR_R, ADDR_MEPC, '0, writebackTag());
            issue("trap", CSR_R, ADDR_MCAUSE, '0, writebackTag());
            issue("trap", CSR_R, ADDR_MTVAL, '0, writebackTag());
            issue("trap", CSR_R, ADDR_MSTATUS, '0, writebackTag());
            stopRequests();
            drain();
        end
        chk0.endTest("trap");

        for (i = 0; i < N_TRAP; i++) begin
            sendTrap();
            r = $random(seed);
            issue("mret", CSR_RW, ADDR_MSTATUS,
                  {19'b0, r[0], r[0], 3'b0, r[1], 3'b0, r[2], 3'b0}, nextTag());
            issue("mret", CSR_RW, ADDR_MEPC, $random(seed), nextTag());
            issue("mret", CSR_MRET, '0, '0, nextTag());
            issue("mret", CSR_R, ADDR_MSTATUS, '0, writebackTag());
            stopRequests();
            drain();
            chk0.checkCtrl("mret", expectedCtrl());
        end
        chk0.endTest("mret");

        ensureMachine();
        cntA = {$random(seed), $random(seed)};
        cntB = {$random(seed), $random(seed)};
        issue("counters", CSR_RWI, ADDR_MCOUNTINHIBIT, 32'd5, nextTag()); // stop both
        issue("counters", CSR_RW, ADDR_MCYCLE, cntA[31:0], NOWB | nextTag());
        issue("counters", CSR_RW, ADDR_MCYCLEH, cntA[63:32], NOWB | nextTag());
        issue("counters", CSR_RW, ADDR_MINSTRET, cntB[31:0], nextTag());
        issue("counters", CSR_RW, ADDR_MINSTRETH, cntB[63:32], nextTag());
        issue("counters", CSR_R, ADDR_MCYCLE, '0, writebackTag());
        issue("counters", CSR_R, ADDR_MCYCLEH, '0, writebackTag());
        issue("counters", CSR_R, ADDR_MINSTRET, '0, writebackTag());
        issue("counters", CSR_R, ADDR_MINSTRETH, '0, writebackTag());
        issue("counters", CSR_RWI, ADDR_MCOUNTINHIBIT, 32'd1, nextTag());
        stopRequests();
        drain();
        sum = 0;
        for (i = 0; i < N_COMMIT; i++) begin
            c = $unsigned($random(seed)) % (COMMIT_WIDTH + 1);
            @(posedge clk);
            commitCount <= CW'(c);
            sum += c;
        end
        @(posedge clk);
        commitCount <= '0;
        mInstret = mInstret + counter_t'(sum);
        issue("counters", CSR_R, ADDR_MINSTRET, '0, writebackTag());
        issue("counters", CSR_R, ADDR_MINSTRETH, '0, writebackTag());
        stopRequests();
        drain();
        chk0.endTest("counters");

        for (i = 0; i < N_IRQ; i++) begin
            ensureMachine();
            r = $random(seed);
            @(posedge clk);
            timerIrq <= r[0];
            mipMti = r[0];
            issue("irq", CSR_RW, ADDR_MIE, {24'b0, r[1], 3'b0, r[2], 3'b0}, nextTag());
            issue("irq", CSR_RW, ADDR_MIP, {28'b0, r[3], 3'b0}, nextTag());
            issue("irq", CSR_RW, ADDR_MSTATUS,
                  {19'b0, r[4], r[4], 3'b0, r[5], 3'b0, r[6], 3'b0}, nextTag());
            if (r[7]) issue("irq", CSR_MRET, '0, '0, nextTag()); // sometimes drop to user
            stopRequests();
            drain();
            chk0.checkCtrl("irq", expectedCtrl());
        end
        chk0.endTest("irq");

        chk0.printCounts();
        if (chk0.errors == 0 && dut0.asserts0.failCount == 0 && chk0.outstanding() == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== tb/csrUnit_asserts.sv ====
module csrUnit_asserts import csrPkg::*; (
    input logic       clk,
    input logic       rst,
    input csrReq_t    req,
    input trapInfo_t  trap,
    input decoded_t   dec,
    input csrResult_t res
);

    int failCount = 0;

    assert property (@(posedge clk) rst |=> !res.valid)
        else begin
            failCount++;
            $error("result valid is set right after reset");
        end

    // traps only arrive with an empty pipeline
    assert property (@(posedge clk) disable iff (rst) trap.valid |-> !(req.valid || dec.valid))
        else begin
            failCount++;
            $error("trap reported while a request is in flight");
        end

    assert property (@(posedge clk) disable iff (rst) res.valid |-> !$isunknown(res.flags))
        else begin
            failCount++;
            $error("result flags hold an unknown value");
        end

    assert property (@(posedge clk) disable iff (rst) req.valid |-> ##2 res.valid)
        else begin
            failCount++;
            $error("result did not arrive two cycles after its request");
        end

endmodule

bind csrUnit csrUnit_asserts asserts0 (
    .clk  (clk),
    .rst  (rst),
    .req  (req),
    .trap (trap),
    .dec  (dec),
    .res  (res)
);

// ==== tb/csrChecker.sv ====
module csrChecker import csrPkg::*; (
    input logic       clk,
    input logic       rst,
    input csrResult_t res,
    input trapCtrl_t  trapCtl
);

    // expected results in request order
    string        nameQ[$];
    tag_t         tagQ[$];
    resultFlags_t flagQ[$];
    xlen_t        dataQ[$];

    int checks     = 0;
    int errors     = 0;
    int testChecks = 0;
    int testErrors = 0;

    task automatic expectResult(input string name, input tag_t tag, input resultFlags_t flags,
                                input xlen_t data);
        nameQ.push_back(name);
        tagQ.push_back(tag);
        flagQ.push_back(flags);
        dataQ.push_back(data);
    endtask

    function automatic int outstanding();
        return nameQ.size();
    endfunction

    task automatic compareField(input string name, input string field, input xlen_t exp,
                                input xlen_t act);
        if (exp !== act) begin
            $display("FAIL %s: %s expected %h, got %h", name, field, exp, act);
            errors++;
            testErrors++;
        end
    endtask

    always @(posedge clk) begin
        string name;
        if (!rst && res.valid) begin
            if (nameQ.size() == 0) begin
                $display("a result with tag %h arrived while no request was waiting", res.tag);
                errors++;
                testErrors++;
            end else begin
                name = nameQ.pop_front();
                checks++;
                testChecks++;
                compareField(name, "tag", xlen_t'(tagQ.pop_front()), xlen_t'(res.tag));
                compareField(name, "flags", xlen_t'(flagQ.pop_front()), xlen_t'(res.flags));
                compareField(name, "data", dataQ.pop_front(), res.data);
            end
        end
    end

    // trap control is combinational so look at it mid-cycle
    task automatic checkCtrl(input string name, input trapCtrl_t exp);
        @(negedge clk);
        checks++;
        testChecks++;
        if (trapCtl !== exp) begin
            $display("FAIL %s: trapCtl expected %h, got %h", name, exp, trapCtl);
            errors++;
            testErrors++;
        end
    endtask

    task automatic endTest(input string name);
        $display("test %s done: %0d checks, %0d errors", name, testChecks, testErrors);
        testChecks = 0;
        testErrors = 0;
    endtask

    task automatic printCounts();
        $display("all tests: %0d checks, %0d errors", checks, errors);
    endtask

endmodule

// ==== verilog/csrUnit.sv ====
module csrUnit import csrPkg::*; #(
    parameter int COMMIT_WIDTH = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  csrReq_t                           req,
    input  trapInfo_t                         trap,
    input  logic [$clog2(COMMIT_WIDTH+1)-1:0] commitCount,
    input  logic                              timerIrq,
    output csrResult_t                        res,
    output trapCtrl_t                         trapCtl
);

    decoded_t      dec;
    counterWrite_t cntWr;
    counterVals_t  cnt;

    csrDecode decode0 (
        .clk (clk),
        .rst (rst),
        .req (req),
        .dec (dec)
    );

    csrExecute execute0 (
        .clk      (clk),
        .rst      (rst),
        .dec      (dec),
        .trap     (trap),
        .timerIrq (timerIrq),
        .cnt      (cnt),
        .cntWr    (cntWr),
        .res      (res),
        .trapCtl  (trapCtl)
    );

    csrCounters #(
        .COMMIT_WIDTH (COMMIT_WIDTH)
    ) counters0 (
        .clk         (clk),
        .rst         (rst),
        .commitCount (commitCount),
        .cntWr       (cntWr),
        .cnt         (cnt)
    );

endmodule

// ==== verilog/csrCounters.sv ====
module csrCounters import csrPkg::*; #(
    parameter int COMMIT_WIDTH = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [$clog2(COMMIT_WIDTH+1)-1:0] commitCount,
    input  counterWrite_t                     cntWr,
    output counterVals_t                      cnt
);

    counter_t   mcycle;
    counter_t   minstret;
    logic [2:0] inhibit;

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle   <= '0;
            minstret <= '0;
            inhibit  <= '0;
        end else begin
            if (!inhibit[0]) begin
                mcycle <= mcycle + 64'd1;
            end
            if (!inhibit[2]) begin
                minstret <= minstret + counter_t'(commitCount);
            end

            // a write wins over this cycle's increment
            if (cntWr.valid) begin
                case (cntWr.sel)
                    SEL_MCYCLE:    mcycle <= {mcycle[63:32], cntWr.data};
                    SEL_MCYCLEH:   mcycle <= {cntWr.data, mcycle[31:0]};
                    SEL_MINSTRET:  minstret <= {minstret[63:32], cntWr.data};
                    SEL_MINSTRETH: minstret <= {cntWr.data, minstret[31:0]};
                    SEL_MCOUNTINHIBIT: begin
                        inhibit <= {cntWr.data[2], 1'b0, cntWr.data[0]}; // no time counter
                    end
                    default: ;
                endcase
            end
        end
    end

    assign cnt.mcycle   = mcycle;
    assign cnt.minstret = minstret;
    assign cnt.inhibit  = inhibit;

endmodule

// ==== verilog/csrExecute.sv ====
module csrExecute import csrPkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  decoded_t      dec,
    input  trapInfo_t     trap,
    input  logic          timerIrq,
    input  counterVals_t  cnt,
    output counterWrite_t cntWr,
    output csrResult_t    res,
    output trapCtrl_t     trapCtl
);

    privLevel_t  priv;
    logic        mstatusMie;
    logic        mstatusMpie;
    privLevel_t  mstatusMpp;
    logic [29:0] mtvecBase;
    xlen_t       mepc;
    logic        mcauseInt;
    cause_t      mcauseCode;
    xlen_t       mtval;
    xlen_t       mscratch;
    logic        mieMsi;
    logic        mieMti;
    logic        mipMsi;
    logic        mipMti;
    logic [30:0] retvec;

    xlen_t       rdata;
    xlen_t       operand;
    xlen_t       wdata;
    logic        isMret;
    logic        writesCsr;
    logic        illegal;
    logic        irqEnabled;
    logic        irqPending;
    cause_t      irqCause;

    always_comb begin
        rdata = '0;
        case (dec.sel)
            SEL_MSTATUS: begin
                rdata[3]     = mstatusMie;
                rdata[7]     = mstatusMpie;
                rdata[12:11] = mstatusMpp;
            end
            SEL_MTVEC:         rdata = {mtvecBase, 2'b00};
            SEL_MEPC:          rdata = mepc;
            SEL_MCAUSE:        rdata = {mcauseInt, 27'b0, mcauseCode};
            SEL_MTVAL:         rdata = mtval;
            SEL_MSCRATCH:      rdata = mscratch;
            SEL_MIE: begin
                rdata[IRQ_MSI] = mieMsi;
                rdata[IRQ_MTI] = mieMti;
            end
            SEL_MIP: begin
                rdata[IRQ_MSI] = mipMsi;
                rdata[IRQ_MTI] = mipMti;
            end
            SEL_MCYCLE:        rdata = cnt.mcycle[31:0];
            SEL_MCYCLEH:       rdata = cnt.mcycle[63:32];
            SEL_MINSTRET:      rdata = cnt.minstret[31:0];
            SEL_MINSTRETH:     rdata = cnt.minstret[63:32];
            SEL_MCOUNTINHIBIT: rdata = {29'b0, cnt.inhibit};
            SEL_MISA:          rdata = MISA_VALUE;
            default:           rdata = '0; // zero and unknown
        endcase
    end

    assign isMret    = (dec.op == CSR_MRET);
    assign writesCsr = (dec.op != CSR_R) && !isMret;
    assign operand   = (dec.op inside {CSR_RWI, CSR_RSI, CSR_RCI}) ? {27'b0, dec.uimm} : dec.src;

    always_comb begin
        case (dec.op)
            CSR_RS, CSR_RSI: wdata = rdata | operand;
            CSR_RC, CSR_RCI: wdata = rdata & ~operand;
            default:         wdata = operand;
        endcase
    end

    // mret only cares about the current mode, not the address
    assign illegal = isMret ? (priv == PRIV_USER)
                            : (dec.sel == SEL_NONE) || (2'(priv) < dec.minPriv)
                              || (writesCsr && dec.readOnly);

    assign cntWr.valid = dec.valid && !illegal && writesCsr
                         && (dec.sel inside {SEL_MCYCLE, SEL_MCYCLEH, SEL_MINSTRET,
                                             SEL_MINSTRETH, SEL_MCOUNTINHIBIT});
    assign cntWr.sel   = dec.sel;
    assign cntWr.data  = wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            priv        <= PRIV_MACHINE;
            mstatusMie  <= 1'b0;
            mstatusMpie <= 1'b0;
            mstatusMpp  <= PRIV_USER;
            mtvecBase   <= '0;
            mepc        <= '0;
            mcauseInt   <= 1'b0;
            mcauseCode  <= '0;
            mtval       <= '0;
            mscratch    <= '0;
            mieMsi      <= 1'b0;
            mieMti      <= 1'b0;
            mipMsi      <= 1'b0;
            mipMti      <= 1'b0;
            retvec      <= '0;
        end else begin
            mipMti <= timerIrq;
            if (dec.valid && !illegal) begin
                if (isMret) begin
                    mstatusMie <= mstatusMpie;
                    priv       <= mstatusMpp;
                    mstatusMpp <= PRIV_USER;
                    retvec     <= mepc[31:1];
                end else if (writesCsr) begin
                    case (dec.sel)
                        SEL_MSTATUS: begin
                            mstatusMie  <= wdata[3];
                            mstatusMpie <= wdata[7];
                            // only U and M exist
                            mstatusMpp  <= (wdata[12:11] == 2'b11) ? PRIV_MACHINE : PRIV_USER;
                        end
                        SEL_MTVEC:    mtvecBase <= wdata[31:2]; // direct mode only
                        SEL_MEPC:     mepc <= {wdata[31:1], 1'b0};
                        SEL_MCAUSE: begin
                            mcauseInt  <= wdata[31];
                            mcauseCode <= wdata[3:0];
                        end
                        SEL_MTVAL:    mtval <= wdata;
                        SEL_MSCRATCH: mscratch <= wdata;
                        SEL_MIE: begin
                            mieMsi <= wdata[IRQ_MSI];
                            mieMti <= wdata[IRQ_MTI];
                        end
                        SEL_MIP:      mipMsi <= wdata[IRQ_MSI]; // MTIP tracks timerIrq
                        default: ;    // counters live in csrCounters
                    endcase
                end
            end
            if (trap.valid) begin
                mepc        <= {trap.pc[31:1], 1'b0};
                mcauseInt   <= trap.isInterrupt;
                mcauseCode  <= trap.cause;
                mtval       <= trap.tval;
                mstatusMpie <= mstatusMie;
                mstatusMie  <= 1'b0;
                mstatusMpp  <= priv;
                priv        <= PRIV_MACHINE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= dec.valid;
        end
    end

    always_ff @(posedge clk) begin
        res.tag <= dec.tag;
        if (illegal) begin
            res.flags <= FLAGS_ILLEGAL;
        end else if (isMret) begin
            res.flags <= FLAGS_XRET;
        end else if (writesCsr) begin
            res.flags <= FLAGS_ORDERING;
        end else begin
            res.flags <= FLAGS_NONE;
        end
        res.data <= (dec.tag[$bits(tag_t)-1] || illegal) ? '0 : rdata;
    end

    // MTI wins over MSI
    always_comb begin
        irqEnabled = mstatusMie || (priv == PRIV_USER);
        irqPending = 1'b0;
        irqCause   = '0;
        if (irqEnabled) begin
            if (mipMti && mieMti) begin
                irqPending = 1'b1;
                irqCause   = cause_t'(IRQ_MTI);
            end else if (mipMsi && mieMsi) begin
                irqPending = 1'b1;
                irqCause   = cause_t'(IRQ_MSI);
            end
        end
    end

    assign trapCtl.priv             = priv;
    assign trapCtl.mtvecBase        = mtvecBase;
    assign trapCtl.retvec           = retvec;
    assign trapCtl.interruptPending = irqPending;
    assign trapCtl.interruptCause   = irqCause;

endmodule

// ==== verilog/csrDecode.sv ====
module csrDecode import csrPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  csrReq_t  req,
    output decoded_t dec
);

    csrSel_t sel;
    logic    readOnly;

    always_comb begin
        case (req.addr)
            ADDR_MSTATUS:       sel = SEL_MSTATUS;
            ADDR_MISA:          sel = SEL_MISA;
            ADDR_MIE:           sel = SEL_MIE;
            ADDR_MTVEC:         sel = SEL_MTVEC;
            ADDR_MCOUNTINHIBIT: sel = SEL_MCOUNTINHIBIT;
            ADDR_MSCRATCH:      sel = SEL_MSCRATCH;
            ADDR_MEPC:          sel = SEL_MEPC;
            ADDR_MCAUSE:        sel = SEL_MCAUSE;
            ADDR_MTVAL:         sel = SEL_MTVAL;
            ADDR_MIP:           sel = SEL_MIP;
            ADDR_MCYCLE:        sel = SEL_MCYCLE;
            ADDR_MCYCLEH:       sel = SEL_MCYCLEH;
            ADDR_MINSTRET:      sel = SEL_MINSTRET;
            ADDR_MINSTRETH:     sel = SEL_MINSTRETH;
            ADDR_MHARTID,
            ADDR_MVENDORID:     sel = SEL_ZERO; // hardwired zero
            default:            sel = SEL_NONE;
        endcase
    end

    // misa is fixed on this core, so treat it like the 0xC00-0xFFF range
    assign readOnly = (req.addr[11:10] == 2'b11) || (sel == SEL_MISA);

    always_ff @(posedge clk) begin
        if (rst) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= req.valid;
        end
    end

    always_ff @(posedge clk) begin
        dec.op       <= req.op;
        dec.sel      <= sel;
        dec.readOnly <= readOnly;
        dec.minPriv  <= req.addr[9:8];  // lowest privilege allowed
        dec.src      <= req.src;
        dec.uimm     <= req.uimm;
        dec.tag      <= req.tag;
    end

endmodule

// ==== verilog/csrPkg.sv ====
package csrPkg;

    typedef logic [31:0] xlen_t;
    typedef logic [11:0] csrAddr_t;
    typedef logic [5:0]  tag_t;     // top bit set means no write-back
    typedef logic [4:0]  uimm_t;
    typedef logic [3:0]  cause_t;
    typedef logic [63:0] counter_t;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'd0,
        PRIV_MACHINE = 2'd3
    } privLevel_t;

    typedef enum logic [2:0] {
        CSR_R, CSR_RW, CSR_RS, CSR_RC, CSR_RWI, CSR_RSI, CSR_RCI, CSR_MRET
    } csrOp_t;

    typedef enum logic [3:0] {
        SEL_MSTATUS, SEL_MTVEC, SEL_MEPC, SEL_MCAUSE,
        SEL_MTVAL, SEL_MSCRATCH, SEL_MIE, SEL_MIP,
        SEL_MCYCLE, SEL_MCYCLEH, SEL_MINSTRET, SEL_MINSTRETH,
        SEL_MCOUNTINHIBIT, SEL_MISA, SEL_ZERO, SEL_NONE
    } csrSel_t;

    typedef enum logic [1:0] {
        FLAGS_NONE, FLAGS_ORDERING, FLAGS_XRET, FLAGS_ILLEGAL
    } resultFlags_t;

    localparam csrAddr_t ADDR_MSTATUS       = 12'h300;
    localparam csrAddr_t ADDR_MISA          = 12'h301;
    localparam csrAddr_t ADDR_MIE           = 12'h304;
    localparam csrAddr_t ADDR_MTVEC         = 12'h305;
    localparam csrAddr_t ADDR_MCOUNTINHIBIT = 12'h320;
    localparam csrAddr_t ADDR_MSCRATCH      = 12'h340;
    localparam csrAddr_t ADDR_MEPC          = 12'h341;
    localparam csrAddr_t ADDR_MCAUSE        = 12'h342;
    localparam csrAddr_t ADDR_MTVAL         = 12'h343;
    localparam csrAddr_t ADDR_MIP           = 12'h344;
    localparam csrAddr_t ADDR_MCYCLE        = 12'hB00;
    localparam csrAddr_t ADDR_MINSTRET      = 12'hB02;
    localparam csrAddr_t ADDR_MCYCLEH       = 12'hB80;
    localparam csrAddr_t ADDR_MINSTRETH     = 12'hB82;
    localparam csrAddr_t ADDR_MVENDORID     = 12'hF11;
    localparam csrAddr_t ADDR_MHARTID       = 12'hF14;

    localparam xlen_t MISA_VALUE = 32'h4010_0100; // RV32, I and U

    localparam int IRQ_MSI = 3;
    localparam int IRQ_MTI = 7;

    typedef struct packed {
        logic     valid;
        csrOp_t   op;
        csrAddr_t addr;
        xlen_t    src;
        uimm_t    uimm;
        tag_t     tag;
    } csrReq_t;

    typedef struct packed {
        logic       valid;
        csrOp_t     op;
        csrSel_t    sel;
        logic       readOnly;
        logic [1:0] minPriv;
        xlen_t      src;
        uimm_t      uimm;
        tag_t       tag;
    } decoded_t;

    typedef struct packed {
        logic         valid;
        tag_t         tag;
        resultFlags_t flags;
        xlen_t        data;
    } csrResult_t;

    typedef struct packed {
        logic   valid;
        logic   isInterrupt;
        cause_t cause;
        xlen_t  pc;
        xlen_t  tval;
    } trapInfo_t;

    typedef struct packed {
        privLevel_t  priv;
        logic [29:0] mtvecBase;
        logic [30:0] retvec;
        logic        interruptPending;
        cause_t      interruptCause;
    } trapCtrl_t;

    typedef struct packed {
        logic    valid;
        csrSel_t sel;
        xlen_t   data;
    } counterWrite_t;

    typedef struct packed {
        counter_t   mcycle;
        counter_t   minstret;
        logic [2:0] inhibit;
    } counterVals_t;

endpackage
